//--- verilog/backend_defs.svh
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// machine word
`define DATA_W 32

// architectural registers, r0 reads zero
`define REG_NUM 32
`define REG_AW 5

// stallable stages: ex, m1, m2
`define STAGE_NUM 3

`endif

//--- verilog/isa_pkg.sv
`include "backend_defs.svh"

package isa_pkg;

	// top six bits of every word
	typedef enum logic [5:0] {
		OP_NOP  = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_XOR  = 6'd5,
		OP_ADDI = 6'd6,
		OP_LUI  = 6'd7,
		OP_LW   = 6'd8,
		OP_SW   = 6'd9
	} opcode_e;

	// register form
	typedef struct packed {
		opcode_e           opcode;
		logic [`REG_AW-1:0] rd;
		logic [`REG_AW-1:0] rs1;
		logic [`REG_AW-1:0] rs2;
		logic [10:0]        unused;
	} r_form_s;

	// immediate form, sw keeps its data register in rd
	typedef struct packed {
		opcode_e           opcode;
		logic [`REG_AW-1:0] rd;
		logic [`REG_AW-1:0] rs1;
		logic [15:0]        imm;
	} i_form_s;

	// same 32 bits, two views
	typedef union packed {
		r_form_s r;
		i_form_s i;
	} inst_word_u;

endpackage

//--- verilog/pipe_pkg.sv
package pipe_pkg;

	// what a pipe does with the op
	typedef enum logic [1:0] {
		UOP_ALU   = 2'd0,
		UOP_LOAD  = 2'd1,
		UOP_STORE = 2'd2,
		UOP_NONE  = 2'd3
	} uop_e;

	// alu function, passb moves operand b through
	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_XOR   = 3'd4,
		ALU_PASSB = 3'd5
	} alu_op_e;

	// where an ex operand comes from
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_M1  = 2'd1,
		FWD_M2  = 2'd2,
		FWD_WB  = 2'd3
	} fwd_src_e;

endpackage

//--- verilog/inst_decoder.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module inst_decoder (
	input  isa_pkg::inst_word_u  inst_i,
	input  logic                 valid_i,
	output pipe_pkg::uop_e       uop_o,
	output pipe_pkg::alu_op_e    alu_op_o,
	output logic [`REG_AW-1:0]   rd_o,
	output logic [`REG_AW-1:0]   rs1_o,
	output logic [`REG_AW-1:0]   rs2_o,
	output logic                 use_rs2_o,
	output logic                 use_imm_o,
	output logic [`DATA_W-1:0]   imm_o
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [`DATA_W-1:0] imm_sext;

	// both forms share the opcode position
	assign imm_sext = {{(`DATA_W-16){inst_i.i.imm[15]}}, inst_i.i.imm};

	always_comb begin
		uop_o     = UOP_NONE;
		alu_op_o  = ALU_ADD;
		rd_o      = '0;
		rs1_o     = '0;
		rs2_o     = '0;
		use_rs2_o = 1'b0;
		use_imm_o = 1'b0;
		imm_o     = imm_sext;
		if (valid_i) begin
			case (inst_i.r.opcode)
				OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
					uop_o     = UOP_ALU;
					rd_o      = inst_i.r.rd;
					rs1_o     = inst_i.r.rs1;
					rs2_o     = inst_i.r.rs2;
					use_rs2_o = 1'b1;
					case (inst_i.r.opcode)
						OP_SUB:  alu_op_o = ALU_SUB;
						OP_AND:  alu_op_o = ALU_AND;
						OP_OR:   alu_op_o = ALU_OR;
						OP_XOR:  alu_op_o = ALU_XOR;
						default: alu_op_o = ALU_ADD;
					endcase
				end
				OP_ADDI, OP_LW: begin
					uop_o     = (inst_i.i.opcode == OP_LW) ? UOP_LOAD : UOP_ALU;
					rd_o      = inst_i.i.rd;
					rs1_o     = inst_i.i.rs1;
					use_imm_o = 1'b1;
				end
				OP_LUI: begin
					// upper half, rs1 stays r0
					uop_o     = UOP_ALU;
					alu_op_o  = ALU_PASSB;
					rd_o      = inst_i.i.rd;
					use_imm_o = 1'b1;
					imm_o     = {inst_i.i.imm, 16'h0};
				end
				OP_SW: begin
					// data register moves to rs2, nothing written back
					uop_o     = UOP_STORE;
					rs1_o     = inst_i.i.rs1;
					rs2_o     = inst_i.i.rd;
					use_rs2_o = 1'b1;
					use_imm_o = 1'b1;
				end
				default: uop_o = UOP_NONE;
			endcase
		end
	end

endmodule

//--- verilog/issue_unit.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module issue_unit (
	input  logic [1:0]                 valid_i,
	input  pipe_pkg::uop_e [1:0]       uop_i,
	input  logic [1:0][`REG_AW-1:0]    rd_i,
	input  logic [1:0][`REG_AW-1:0]    rs1_i,
	input  logic [1:0][`REG_AW-1:0]    rs2_i,
	input  logic [1:0]                 use_rs2_i,
	input  logic [`REG_AW-1:0]         ex_load_rd_i,
	input  logic                       ex_load_valid_i,
	input  logic [`REG_AW-1:0]         m1_load_rd_i,
	input  logic                       m1_load_valid_i,
	input  logic                       stall_i,
	output logic [1:0]                 issue_o,
	output logic                       revert_o
);
	import pipe_pkg::*;

	logic [1:0] is_mem;
	logic [1:0] load_hz;
	logic       pair_dep;

	// true when reg is a pending load result
	function automatic logic load_pending(input logic [`REG_AW-1:0] r);
		load_pending = (r != '0) &&
			((ex_load_valid_i && r == ex_load_rd_i) ||
			 (m1_load_valid_i && r == m1_load_rd_i));
	endfunction

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			is_mem[s]  = (uop_i[s] == UOP_LOAD) || (uop_i[s] == UOP_STORE);
			// rs1 is r0 when unused, so no guard needed
			load_hz[s] = load_pending(rs1_i[s]) ||
				(use_rs2_i[s] && load_pending(rs2_i[s]));
		end
	end

	// slot 1 against slot 0
	always_comb begin
		pair_dep = 1'b0;
		if (rd_i[0] != '0) begin
			if (rs1_i[1] == rd_i[0])
				pair_dep = 1'b1;
			if (use_rs2_i[1] && rs2_i[1] == rd_i[0])
				pair_dep = 1'b1;
			// same destination, keep write order simple
			if (rd_i[1] == rd_i[0])
				pair_dep = 1'b1;
		end
		// only the main pipe has a memory port
		if (is_mem[0] && is_mem[1])
			pair_dep = 1'b1;
	end

	// in order, slot 1 only behind slot 0
	assign issue_o[0] = valid_i[0] & ~stall_i & ~load_hz[0];
	assign issue_o[1] = issue_o[0] & valid_i[1] & ~load_hz[1] & ~pair_dep;

	// memory op in slot 1 swaps to pipe 0
	assign revert_o = issue_o[1] & is_mem[1] & ~is_mem[0];

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module reg_file #(
	parameter int READ_PORTS  = 4,
	parameter int WRITE_PORTS = 2
) (
	input  logic                                  clk,
	input  logic                                  rst_n_i,
	input  logic [WRITE_PORTS-1:0]                w_en_i,
	input  logic [WRITE_PORTS-1:0][`REG_AW-1:0]   w_addr_i,
	input  logic [WRITE_PORTS-1:0][`DATA_W-1:0]   w_data_i,
	input  logic [READ_PORTS-1:0][`REG_AW-1:0]    r_addr_i,
	output logic [READ_PORTS-1:0][`DATA_W-1:0]    r_data_o
);

	logic [`DATA_W-1:0] regs [`REG_NUM];

	// higher write port lands last
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int r = 0; r < `REG_NUM; r++)
				regs[r] <= '0;
		end else begin
			for (int w = 0; w < WRITE_PORTS; w++)
				if (w_en_i[w] && w_addr_i[w] != '0)
					regs[w_addr_i[w]] <= w_data_i[w];
		end
	end

	// same cycle write shows up on the read
	always_comb begin
		for (int p = 0; p < READ_PORTS; p++) begin
			r_data_o[p] = regs[r_addr_i[p]];
			for (int w = 0; w < WRITE_PORTS; w++)
				if (w_en_i[w] && w_addr_i[w] == r_addr_i[p])
					r_data_o[p] = w_data_i[w];
			// r0 is hardwired
			if (r_addr_i[p] == '0)
				r_data_o[p] = '0;
		end
	end

endmodule

//--- verilog/backend_pipeline.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module backend_pipeline #(
	parameter bit MAIN_PIPE = 1'b0
) (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic [`STAGE_NUM-1:0]     stall_vec_i,
	input  logic                      issue_i,
	input  logic                      revert_i,
	input  pipe_pkg::uop_e            uop_i,
	input  pipe_pkg::alu_op_e         alu_op_i,
	input  logic [`REG_AW-1:0]        rd_i,
	input  logic [`REG_AW-1:0]        rs1_i,
	input  logic [`REG_AW-1:0]        rs2_i,
	input  logic                      use_imm_i,
	input  logic [`DATA_W-1:0]        imm_i,
	input  logic [`DATA_W-1:0]        op_a_i,
	input  logic [`DATA_W-1:0]        op_b_i,
	input  logic                      peer_m1_valid_i,
	input  logic [`REG_AW-1:0]        peer_m1_rd_i,
	input  logic [`DATA_W-1:0]        peer_m1_data_i,
	input  logic                      peer_m2_valid_i,
	input  logic [`REG_AW-1:0]        peer_m2_rd_i,
	input  logic [`DATA_W-1:0]        peer_m2_data_i,
	input  logic                      peer_wb_valid_i,
	input  logic [`REG_AW-1:0]        peer_wb_rd_i,
	input  logic [`DATA_W-1:0]        peer_wb_data_i,
	output logic                      m1_valid_o,
	output logic [`REG_AW-1:0]        m1_rd_o,
	output logic [`DATA_W-1:0]        m1_data_o,
	output logic                      m2_valid_o,
	output logic [`REG_AW-1:0]        m2_rd_o,
	output logic [`DATA_W-1:0]        m2_data_o,
	output logic                      wb_valid_o,
	output logic [`REG_AW-1:0]        wb_rd_o,
	output logic [`DATA_W-1:0]        wb_data_o,
	output logic                      wb_revert_o,
	output logic [`STAGE_NUM-1:0]     stall_req_o,
	output logic [`REG_AW-1:0]        ex_load_rd_o,
	output logic                      ex_load_valid_o,
	output logic [`REG_AW-1:0]        m1_load_rd_o,
	output logic                      m1_load_valid_o,
	output logic                      mem_req_valid_o,
	input  logic                      mem_req_ready_i,
	output logic                      mem_req_we_o,
	output logic [`DATA_W-1:0]        mem_req_addr_o,
	output logic [`DATA_W-1:0]        mem_req_wdata_o,
	input  logic                      mem_resp_valid_i,
	input  logic [`DATA_W-1:0]        mem_resp_rdata_i
);
	import pipe_pkg::*;

	// ex stage
	logic               ex_valid;
	uop_e               ex_uop;
	alu_op_e            ex_alu_op;
	logic [`REG_AW-1:0] ex_rd, ex_rs1, ex_rs2;
	logic               ex_use_imm, ex_revert;
	logic [`DATA_W-1:0] ex_imm, ex_op_a, ex_op_b;
	// m1, m2, wb stages
	logic               m1_valid, m2_valid, wb_valid;
	uop_e               m1_uop, m2_uop;
	logic [`REG_AW-1:0] m1_rd, m2_rd, wb_rd;
	logic [`DATA_W-1:0] m1_result, m1_wdata, m2_result, wb_data;
	logic               m1_revert, m2_revert, wb_revert;

	fwd_src_e           src [2];
	logic [1:0]         src_peer;
	logic [1:0][`REG_AW-1:0] rs;
	logic [1:0][`DATA_W-1:0] reg_val, res_val;
	logic [`DATA_W-1:0] alu_b, ex_result, m2_final;
	logic               m1_mem, m2_mem;

	// operand sources, later checks are younger and win
	assign rs      = {ex_rs2, ex_rs1};
	assign reg_val = {ex_op_b, ex_op_a};
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			src[k]      = FWD_REG;
			src_peer[k] = 1'b0;
			if (rs[k] != '0) begin
				if (wb_valid_o && wb_rd_o == rs[k])           src[k] = FWD_WB;
				if (peer_wb_valid_i && peer_wb_rd_i == rs[k]) begin
					src[k] = FWD_WB;
					src_peer[k] = 1'b1;
				end
				if (m2_valid_o && m2_rd_o == rs[k]) begin
					src[k] = FWD_M2;
					src_peer[k] = 1'b0;
				end
				if (peer_m2_valid_i && peer_m2_rd_i == rs[k]) begin
					src[k] = FWD_M2;
					src_peer[k] = 1'b1;
				end
				if (m1_valid_o && m1_rd_o == rs[k]) begin
					src[k] = FWD_M1;
					src_peer[k] = 1'b0;
				end
				if (peer_m1_valid_i && peer_m1_rd_i == rs[k]) begin
					src[k] = FWD_M1;
					src_peer[k] = 1'b1;
				end
			end
			case (src[k])
				FWD_M1:  res_val[k] = src_peer[k] ? peer_m1_data_i : m1_data_o;
				FWD_M2:  res_val[k] = src_peer[k] ? peer_m2_data_i : m2_data_o;
				FWD_WB:  res_val[k] = src_peer[k] ? peer_wb_data_i : wb_data_o;
				default: res_val[k] = reg_val[k];
			endcase
		end
	end

	// alu, also the address adder for memory ops
	assign alu_b = ex_use_imm ? ex_imm : res_val[1];
	always_comb begin
		case (ex_alu_op)
			ALU_SUB:   ex_result = res_val[0] - alu_b;
			ALU_AND:   ex_result = res_val[0] & alu_b;
			ALU_OR:    ex_result = res_val[0] | alu_b;
			ALU_XOR:   ex_result = res_val[0] ^ alu_b;
			ALU_PASSB: ex_result = alu_b;
			default:   ex_result = res_val[0] + alu_b;
		endcase
	end

	// stage valids
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_valid <= 1'b0;
			m1_valid <= 1'b0;
			m2_valid <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			if (!stall_vec_i[0]) ex_valid <= issue_i;
			// bubble behind a stalled stage
			if (!stall_vec_i[1]) m1_valid <= ex_valid & ~stall_vec_i[0];
			if (!stall_vec_i[2]) m2_valid <= m1_valid & ~stall_vec_i[1];
			wb_valid <= m2_valid & ~stall_vec_i[2];
		end
	end

	// stage payloads
	always_ff @(posedge clk) begin
		if (!stall_vec_i[0]) begin
			ex_uop     <= uop_i;
			ex_alu_op  <= alu_op_i;
			ex_rd      <= rd_i;
			ex_rs1     <= rs1_i;
			ex_rs2     <= rs2_i;
			ex_use_imm <= use_imm_i;
			ex_imm     <= imm_i;
			ex_op_a    <= op_a_i;
			ex_op_b    <= op_b_i;
			ex_revert  <= revert_i;
		end else begin
			// held op keeps catching results before they retire
			ex_op_a <= res_val[0];
			ex_op_b <= res_val[1];
		end
		if (!stall_vec_i[1]) begin
			m1_uop    <= ex_uop;
			m1_rd     <= ex_rd;
			m1_result <= ex_result;
			m1_wdata  <= res_val[1];
			m1_revert <= ex_revert;
		end
		if (!stall_vec_i[2]) begin
			m2_uop    <= m1_uop;
			m2_rd     <= m1_rd;
			m2_result <= m1_result;
			m2_revert <= m1_revert;
		end
		wb_rd     <= m2_rd;
		wb_data   <= m2_final;
		wb_revert <= m2_revert;
	end

	// memory side, main pipe only
	assign m1_mem = MAIN_PIPE && m1_valid && (m1_uop == UOP_LOAD || m1_uop == UOP_STORE);
	assign m2_mem = MAIN_PIPE && m2_valid && (m2_uop == UOP_LOAD || m2_uop == UOP_STORE);
	// one outstanding, wait for m2 to drain
	assign mem_req_valid_o = m1_mem & ~m2_mem;
	assign mem_req_we_o    = m1_uop == UOP_STORE;
	assign mem_req_addr_o  = m1_result;
	assign mem_req_wdata_o = m1_wdata;
	assign m2_final = (m2_mem && m2_uop == UOP_LOAD) ? mem_resp_rdata_i : m2_result;

	assign stall_req_o[0] = 1'b0;
	assign stall_req_o[1] = m1_mem & ~(mem_req_valid_o & mem_req_ready_i);
	assign stall_req_o[2] = m2_mem & ~mem_resp_valid_i;

	// load rd for the issue interlock
	assign ex_load_valid_o = MAIN_PIPE && ex_valid && ex_uop == UOP_LOAD;
	assign ex_load_rd_o    = ex_rd;
	assign m1_load_valid_o = m1_valid && m1_uop == UOP_LOAD;
	assign m1_load_rd_o    = m1_rd;

	// forwarding buses, loads only count once in wb
	assign m1_valid_o  = m1_valid && m1_uop == UOP_ALU;
	assign m1_rd_o     = m1_rd;
	assign m1_data_o   = m1_result;
	assign m2_valid_o  = m2_valid && m2_uop == UOP_ALU;
	assign m2_rd_o     = m2_rd;
	assign m2_data_o   = m2_result;
	assign wb_valid_o  = wb_valid;
	assign wb_rd_o     = wb_rd;
	assign wb_data_o   = wb_data;
	assign wb_revert_o = wb_revert;

endmodule

//--- verilog/backend.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module backend (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  isa_pkg::inst_word_u [1:0]      inst_i,
	input  logic [1:0]                     inst_valid_i,
	output logic [1:0]                     issue_num_o,
	output logic                           mem_req_valid_o,
	input  logic                           mem_req_ready_i,
	output logic                           mem_req_we_o,
	output logic [`DATA_W-1:0]             mem_req_addr_o,
	output logic [`DATA_W-1:0]             mem_req_wdata_o,
	input  logic                           mem_resp_valid_i,
	input  logic [`DATA_W-1:0]             mem_resp_rdata_i,
	output logic [1:0]                     commit_valid_o,
	output logic [1:0][`REG_AW-1:0]        commit_rd_o,
	output logic [1:0][`DATA_W-1:0]        commit_data_o
);
	import pipe_pkg::*;

	// per slot decode
	uop_e    [1:0]             uop;
	alu_op_e [1:0]             alu_op;
	logic [1:0][`REG_AW-1:0]   rd, rs1, rs2;
	logic [1:0]                use_rs2, use_imm;
	logic [1:0][`DATA_W-1:0]   imm;
	// issue and stall
	logic [1:0]                issue;
	logic                      revert;
	logic [1:0][`STAGE_NUM-1:0] stall_req;
	logic [`STAGE_NUM-1:0]     stall_vec;
	logic [`REG_AW-1:0]        ex_load_rd, m1_load_rd;
	logic                      ex_load_valid, m1_load_valid;
	// per pipe buses
	logic [3:0][`REG_AW-1:0]   r_addr;
	logic [3:0][`DATA_W-1:0]   r_data;
	logic [1:0]                m1_valid, m2_valid, wb_valid, wb_revert;
	logic [1:0][`REG_AW-1:0]   m1_rd, m2_rd, wb_rd;
	logic [1:0][`DATA_W-1:0]   m1_data, m2_data, wb_data;
	logic [1:0]                wb_commit, cm_v;
	logic [1:0][`REG_AW-1:0]   cm_rd;
	logic [1:0][`DATA_W-1:0]   cm_data;
	// bus and load interlock per pipe, pipe 1 keeps them idle
	logic [1:0]                p_req_valid, p_req_we;
	logic [1:0][`DATA_W-1:0]   p_req_addr, p_req_wdata;
	logic [1:0][`REG_AW-1:0]   p_ex_load_rd, p_m1_load_rd;
	logic [1:0]                p_ex_load_valid, p_m1_load_valid;

	for (genvar s = 0; s < 2; s++) begin : g_dec
		inst_decoder u_dec (
			.inst_i(inst_i[s]), .valid_i(inst_valid_i[s]),
			.uop_o(uop[s]), .alu_op_o(alu_op[s]),
			.rd_o(rd[s]), .rs1_o(rs1[s]), .rs2_o(rs2[s]),
			.use_rs2_o(use_rs2[s]), .use_imm_o(use_imm[s]), .imm_o(imm[s])
		);
	end

	issue_unit u_issue (
		.valid_i(inst_valid_i), .uop_i(uop), .rd_i(rd), .rs1_i(rs1), .rs2_i(rs2),
		.use_rs2_i(use_rs2),
		.ex_load_rd_i(ex_load_rd), .ex_load_valid_i(ex_load_valid),
		.m1_load_rd_i(m1_load_rd), .m1_load_valid_i(m1_load_valid),
		.stall_i(stall_vec[0]), .issue_o(issue), .revert_o(revert)
	);

	// 0, 1 or 2 accepted
	assign issue_num_o = {issue[1], issue[0] & ~issue[1]};

	// a request stalls its stage and everything before it
	always_comb begin
		for (int lvl = 0; lvl < `STAGE_NUM; lvl++) begin
			stall_vec[lvl] = 1'b0;
			for (int r = lvl; r < `STAGE_NUM; r++)
				stall_vec[lvl] |= stall_req[0][r] | stall_req[1][r];
		end
	end

	// wb of both pipes writes back
	reg_file #(.READ_PORTS(4), .WRITE_PORTS(2)) u_regs (
		.clk, .rst_n_i,
		.w_en_i(wb_valid), .w_addr_i(wb_rd), .w_data_i(wb_data),
		.r_addr_i(r_addr), .r_data_o(r_data)
	);

	// pipe p takes slot p ^ revert
	for (genvar p = 0; p < 2; p++) begin : g_pipe
		localparam int PEER = 1 - p;
		logic sel;
		assign sel = (p != 0) ^ revert;
		assign r_addr[2*p]   = rs1[sel];
		assign r_addr[2*p+1] = rs2[sel];

		backend_pipeline #(.MAIN_PIPE(p == 0)) u_pipe (
			.clk, .rst_n_i, .stall_vec_i(stall_vec),
			.issue_i(issue[sel]), .revert_i(revert),
			.uop_i(uop[sel]), .alu_op_i(alu_op[sel]), .rd_i(rd[sel]),
			.rs1_i(rs1[sel]), .rs2_i(rs2[sel]),
			.use_imm_i(use_imm[sel]), .imm_i(imm[sel]),
			.op_a_i(r_data[2*p]), .op_b_i(r_data[2*p+1]),
			.peer_m1_valid_i(m1_valid[PEER]), .peer_m1_rd_i(m1_rd[PEER]),
			.peer_m1_data_i(m1_data[PEER]),
			.peer_m2_valid_i(m2_valid[PEER]), .peer_m2_rd_i(m2_rd[PEER]),
			.peer_m2_data_i(m2_data[PEER]),
			.peer_wb_valid_i(wb_valid[PEER]), .peer_wb_rd_i(wb_rd[PEER]),
			.peer_wb_data_i(wb_data[PEER]),
			.m1_valid_o(m1_valid[p]), .m1_rd_o(m1_rd[p]), .m1_data_o(m1_data[p]),
			.m2_valid_o(m2_valid[p]), .m2_rd_o(m2_rd[p]), .m2_data_o(m2_data[p]),
			.wb_valid_o(wb_valid[p]), .wb_rd_o(wb_rd[p]), .wb_data_o(wb_data[p]),
			.wb_revert_o(wb_revert[p]), .stall_req_o(stall_req[p]),
			.ex_load_rd_o(p_ex_load_rd[p]), .ex_load_valid_o(p_ex_load_valid[p]),
			.m1_load_rd_o(p_m1_load_rd[p]), .m1_load_valid_o(p_m1_load_valid[p]),
			.mem_req_valid_o(p_req_valid[p]), .mem_req_ready_i(mem_req_ready_i),
			.mem_req_we_o(p_req_we[p]),
			.mem_req_addr_o(p_req_addr[p]), .mem_req_wdata_o(p_req_wdata[p]),
			.mem_resp_valid_i(mem_resp_valid_i), .mem_resp_rdata_i(mem_resp_rdata_i)
		);
	end

	// only pipe 0 talks to memory and holds loads
	assign mem_req_valid_o = p_req_valid[0];
	assign mem_req_we_o    = p_req_we[0];
	assign mem_req_addr_o  = p_req_addr[0];
	assign mem_req_wdata_o = p_req_wdata[0];
	assign ex_load_rd      = p_ex_load_rd[0];
	assign ex_load_valid   = p_ex_load_valid[0];
	assign m1_load_rd      = p_m1_load_rd[0];
	assign m1_load_valid   = p_m1_load_valid[0];

	// put wb back in program order, older first
	always_comb begin
		for (int p = 0; p < 2; p++)
			wb_commit[p] = wb_valid[p] && wb_rd[p] != '0;
		cm_v    = wb_revert[0] ? {wb_commit[0], wb_commit[1]} : wb_commit;
		cm_rd   = wb_revert[0] ? {wb_rd[0], wb_rd[1]} : wb_rd;
		cm_data = wb_revert[0] ? {wb_data[0], wb_data[1]} : wb_data;
		// close the gap when the older one has no rd
		commit_valid_o = cm_v;
		commit_rd_o    = cm_rd;
		commit_data_o  = cm_data;
		if (!cm_v[0]) begin
			commit_valid_o   = {1'b0, cm_v[1]};
			commit_rd_o[0]   = cm_rd[1];
			commit_data_o[0] = cm_data[1];
		end
	end

endmodule

//--- verif/backend_checker.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module backend_checker (
	input logic                 clk,
	input logic                 rst_n_i,
	input logic [1:0]           issue_num_i,
	input logic                 mem_req_valid_i,
	input logic                 mem_req_ready_i,
	input logic                 mem_req_we_i,
	input logic [`DATA_W-1:0]   mem_req_addr_i,
	input logic [`DATA_W-1:0]   mem_req_wdata_i,
	input logic [1:0]           commit_valid_i
);

	// waiting request holds still until ready
	req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		mem_req_valid_i && !mem_req_ready_i |=>
			mem_req_valid_i && $stable(mem_req_we_i) && $stable(mem_req_addr_i) &&
			$stable(mem_req_wdata_i))
		else $error("memory request dropped or changed before it was accepted");

	// two slots only
	issue_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		issue_num_i != 2'd3)
		else $error("issue count out of range");

	// older instruction always on port 0
	commit_order: assert property (@(posedge clk) disable iff (!rst_n_i)
		commit_valid_i[1] |-> commit_valid_i[0])
		else $error("commit port 1 valid without port 0");

	// quiet in reset and on the first cycle out of it
	reset_quiet: assert property (@(posedge clk)
		!rst_n_i |-> !mem_req_valid_i && commit_valid_i == 2'b00)
		else $error("bus request or commit while in reset");
	after_reset_quiet: assert property (@(posedge clk)
		!rst_n_i |=> !mem_req_valid_i && commit_valid_i == 2'b00)
		else $error("bus request or commit right after reset");

endmodule

bind backend backend_checker u_checker (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.issue_num_i(issue_num_o),
	.mem_req_valid_i(mem_req_valid_o),
	.mem_req_ready_i(mem_req_ready_i),
	.mem_req_we_i(mem_req_we_o),
	.mem_req_addr_i(mem_req_addr_o),
	.mem_req_wdata_i(mem_req_wdata_o),
	.commit_valid_i(commit_valid_o)
);

//--- verif/backend_tb.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module backend_tb;
	import isa_pkg::*;

	localparam int MAX_ROWS = 64;

	logic                     clk;
	logic                     rst_n_i;
	inst_word_u [1:0]         inst;
	logic [1:0]               inst_valid;
	logic [1:0]               issue_num;
	logic                     mem_req_valid;
	logic                     mem_req_ready;
	logic                     mem_req_we;
	logic [`DATA_W-1:0]       mem_req_addr;
	logic [`DATA_W-1:0]       mem_req_wdata;
	logic                     mem_resp_valid;
	logic [`DATA_W-1:0]       mem_resp_rdata;
	logic [1:0]               commit_valid;
	logic [1:0][`REG_AW-1:0]  commit_rd;
	logic [1:0][`DATA_W-1:0]  commit_data;

	// program rows: word, expected rd, expected value
	logic [31:0]              prog_word [MAX_ROWS];
	logic [`REG_AW-1:0]       prog_rd [MAX_ROWS];
	logic [`DATA_W-1:0]       prog_val [MAX_ROWS];
	int                       n_rows;
	// rows that should retire, in program order
	int                       exp_rows [$];
	int                       exp_idx;

	// memory model
	logic [`DATA_W-1:0]       mem [64];
	logic                     resp_pending;
	int                       resp_cnt;
	logic [`DATA_W-1:0]       resp_data;

	integer                   seed;
	int                       pc;
	int                       taken;
	int                       cycles;
	int                       limit;
	int                       checks;
	int                       value_errs;
	int                       other_errs;

	backend u_dut (
		.clk(clk), .rst_n_i(rst_n_i),
		.inst_i(inst), .inst_valid_i(inst_valid), .issue_num_o(issue_num),
		.mem_req_valid_o(mem_req_valid), .mem_req_ready_i(mem_req_ready),
		.mem_req_we_o(mem_req_we), .mem_req_addr_o(mem_req_addr),
		.mem_req_wdata_o(mem_req_wdata),
		.mem_resp_valid_i(mem_resp_valid), .mem_resp_rdata_i(mem_resp_rdata),
		.commit_valid_o(commit_valid), .commit_rd_o(commit_rd), .commit_data_o(commit_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// register form word
	function automatic logic [31:0] r_word(input opcode_e op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		return {op, rd, rs1, rs2, 11'd0};
	endfunction

	// immediate form word, sw puts its data register in rd
	function automatic logic [31:0] i_word(input opcode_e op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [15:0] imm);
		return {op, rd, rs1, imm};
	endfunction

	task automatic add_row(input logic [31:0] word, input logic [4:0] rd,
		input logic [31:0] val);
		prog_word[n_rows] = word;
		prog_rd[n_rows]   = rd;
		prog_val[n_rows]  = val;
		// rd 0 never shows on the commit ports
		if (rd != 5'd0)
			exp_rows.push_back(n_rows);
		n_rows++;
	endtask

	task automatic build_program();
		// independent alu pairs
		add_row(i_word(OP_ADDI, 5'd1, 5'd0, 16'd5), 5'd1, 32'd5);
		add_row(i_word(OP_ADDI, 5'd2, 5'd0, 16'd12), 5'd2, 32'd12);
		add_row(i_word(OP_LUI, 5'd3, 5'd0, 16'h1234), 5'd3, 32'h1234_0000);
		add_row(i_word(OP_ADDI, 5'd4, 5'd0, 16'hFFFD), 5'd4, 32'hFFFF_FFFD);
		add_row(r_word(OP_ADD, 5'd5, 5'd1, 5'd2), 5'd5, 32'd17);
		add_row(r_word(OP_SUB, 5'd6, 5'd2, 5'd1), 5'd6, 32'd7);
		add_row(r_word(OP_AND, 5'd7, 5'd2, 5'd4), 5'd7, 32'd12);
		add_row(r_word(OP_OR, 5'd8, 5'd3, 5'd1), 5'd8, 32'h1234_0005);
		add_row(r_word(OP_XOR, 5'd9, 5'd4, 5'd2), 5'd9, 32'hFFFF_FFF1);
		// dependent chain, split pairs, forwarding from m1, m2 and wb
		add_row(i_word(OP_ADDI, 5'd10, 5'd1, 16'd1), 5'd10, 32'd6);
		add_row(r_word(OP_ADD, 5'd10, 5'd10, 5'd10), 5'd10, 32'd12);
		add_row(i_word(OP_ADDI, 5'd11, 5'd10, 16'd3), 5'd11, 32'd15);
		add_row(r_word(OP_SUB, 5'd12, 5'd11, 5'd10), 5'd12, 32'd3);
		add_row(i_word(OP_ADDI, 5'd13, 5'd0, 16'd7), 5'd13, 32'd7);
		add_row(r_word(OP_XOR, 5'd14, 5'd12, 5'd10), 5'd14, 32'd15);
		// same rd twice
		add_row(i_word(OP_ADDI, 5'd15, 5'd0, 16'd1), 5'd15, 32'd1);
		add_row(i_word(OP_ADDI, 5'd15, 5'd0, 16'd2), 5'd15, 32'd2);
		add_row(r_word(OP_ADD, 5'd16, 5'd15, 5'd13), 5'd16, 32'd9);
		// r0 write is dropped and r0 still reads zero
		add_row(i_word(OP_ADDI, 5'd0, 5'd0, 16'd99), 5'd0, 32'd0);
		add_row(r_word(OP_ADD, 5'd17, 5'd0, 5'd1), 5'd17, 32'd5);
		// store then load, load-use
		add_row(i_word(OP_SW, 5'd5, 5'd0, 16'd16), 5'd0, 32'd0);
		add_row(i_word(OP_LW, 5'd18, 5'd0, 16'd16), 5'd18, 32'd17);
		add_row(r_word(OP_ADD, 5'd19, 5'd18, 5'd1), 5'd19, 32'd22);
		add_row(i_word(OP_LW, 5'd20, 5'd0, 16'd8), 5'd20, 32'h1111_0202);
		// alu in slot 0, store in slot 1 swaps to pipe 0
		add_row(i_word(OP_ADDI, 5'd21, 5'd20, 16'd1), 5'd21, 32'h1111_0203);
		add_row(i_word(OP_SW, 5'd9, 5'd0, 16'd40), 5'd0, 32'd0);
		add_row(i_word(OP_LW, 5'd23, 5'd0, 16'd40), 5'd23, 32'hFFFF_FFF1);
		// same again with a load in slot 1
		add_row(i_word(OP_ADDI, 5'd24, 5'd23, 16'd2), 5'd24, 32'hFFFF_FFF3);
		add_row(i_word(OP_LW, 5'd25, 5'd0, 16'd20), 5'd25, 32'h1111_0505);
		add_row(r_word(OP_SUB, 5'd26, 5'd25, 5'd5), 5'd26, 32'h1111_04F4);
		add_row(i_word(OP_SW, 5'd26, 5'd0, 16'd44), 5'd0, 32'd0);
		add_row(i_word(OP_LW, 5'd27, 5'd0, 16'd44), 5'd27, 32'h1111_04F4);
		add_row(i_word(OP_ADDI, 5'd28, 5'd27, 16'd16), 5'd28, 32'h1111_0504);
		add_row(r_word(OP_ADD, 5'd29, 5'd28, 5'd3), 5'd29, 32'h2345_0504);
		add_row(r_word(OP_XOR, 5'd30, 5'd29, 5'd29), 5'd30, 32'd0);
	endtask

	// next two rows of the program, oldest in slot 0
	task automatic present_slots();
		inst_valid = 2'b00;
		inst[0]    = '0;
		inst[1]    = '0;
		for (int s = 0; s < 2; s++) begin
			if (pc + s < n_rows) begin
				inst[s]       = prog_word[pc + s];
				inst_valid[s] = 1'b1;
			end
		end
	endtask

	task automatic check_commits();
		int row;
		for (int p = 0; p < 2; p++) begin
			if (commit_valid[p]) begin
				if (exp_idx >= exp_rows.size()) begin
					$display("commit on port %0d at %0t with nothing left to retire", p, $time);
					other_errs++;
				end else begin
					row = exp_rows[exp_idx];
					checks++;
					assert (commit_rd[p] == prog_rd[row]) else begin
						$display("error at %0t: commit_rd_o[%0d] = %0d, expected %0d",
							$time, p, commit_rd[p], prog_rd[row]);
						value_errs++;
					end
					assert (commit_data[p] == prog_val[row]) else begin
						$display("error at %0t: commit_data_o[%0d] = %h, expected %h",
							$time, p, commit_data[p], prog_val[row]);
						value_errs++;
					end
					exp_idx++;
				end
			end
		end
	endtask

	// mid cycle, everything settled
	task automatic sample_cycle();
		int offered;
		offered = int'(inst_valid[0]) + int'(inst_valid[1]);
		assert (int'(issue_num) <= offered) else begin
			$display("backend took more instructions than offered at %0t", $time);
			other_errs++;
		end
		taken = int'(issue_num);
		check_commits();
		// request taken at the coming edge
		if (mem_req_valid && mem_req_ready) begin
			assert (!resp_pending) else begin
				$display("second memory request at %0t while one is outstanding", $time);
				other_errs++;
			end
			if (mem_req_we) begin
				mem[mem_req_addr[7:2]] = mem_req_wdata;
				resp_data = '0;
			end else begin
				resp_data = mem[mem_req_addr[7:2]];
			end
			resp_pending = 1'b1;
			resp_cnt     = 1 + ($random(seed) & 3);
		end
	endtask

	// just after the edge
	task automatic drive_inputs();
		pc += taken;
		mem_resp_valid = 1'b0;
		if (resp_pending) begin
			resp_cnt--;
			if (resp_cnt == 0) begin
				mem_resp_valid = 1'b1;
				mem_resp_rdata = resp_data;
				resp_pending   = 1'b0;
			end
		end
		mem_req_ready = ($random(seed) & 3) != 0;
		present_slots();
	endtask

	initial begin
		seed           = 48;
		rst_n_i        = 1'b1;
		inst           = '0;
		inst_valid     = 2'b00;
		mem_req_ready  = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_rdata = '0;
		n_rows         = 0;
		exp_idx        = 0;
		pc             = 0;
		taken          = 0;
		cycles         = 0;
		checks         = 0;
		value_errs     = 0;
		other_errs     = 0;
		resp_pending   = 1'b0;
		resp_cnt       = 0;
		resp_data      = '0;
		for (int i = 0; i < 64; i++)
			mem[i] = 32'h1111_0000 + i * 32'h0000_0101;
		build_program();
		// each row gets 12 cycles worst case
		limit = n_rows * 12 + 50;
		#1 rst_n_i = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n_i = 1'b1;
		// nothing offered yet, so nothing may move
		repeat (3) begin
			@(negedge clk);
			assert (commit_valid == 2'b00 && !mem_req_valid && issue_num == 2'd0) else begin
				$display("commit, bus request or issue at %0t before any instruction", $time);
				other_errs++;
			end
		end
		@(posedge clk);
		#1 present_slots();
		while (exp_idx < exp_rows.size() && cycles < limit) begin
			@(negedge clk);
			sample_cycle();
			@(posedge clk);
			#1 drive_inputs();
			cycles++;
		end
		if (cycles >= limit) begin
			$display("timeout after %0d cycles, %0d of %0d commits seen",
				cycles, exp_idx, exp_rows.size());
			other_errs++;
		end
		// stray commits after the last row
		repeat (8) begin
			@(negedge clk);
			check_commits();
		end
		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- backend.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/inst_decoder.sv
verilog/issue_unit.sv
verilog/reg_file.sv
verilog/backend_pipeline.sv
verilog/backend.sv
verif/backend_checker.sv
verif/backend_tb.sv

//--- run.sh
#!/bin/sh
# verilator build and run, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module backend_tb \
	-f backend.f -o sim_backend > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_backend > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
